//--- filelist.f
logic/lsu_pkg.sv
logic/mem_req_issue.sv
logic/req_fifo.sv
logic/lsu.sv
logic/sram_axi.sv
logic/lsu_top.sv
sim/tb_lsu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_lsu -Mdir obj_dir -f filelist.f > build.log 2>&1 \
    && ./obj_dir/Vtb_lsu > sim.log 2>&1 \
    || { echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
grep -q "^Testbench passed$" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; cat sim.log; exit 1; }

//--- sim/tb_lsu.sv
module tb_lsu
    import lsu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_c = 200;

    logic     clk;
    logic     rst_n;
    logic     cmd_valid;
    mem_cmd_t cmd;
    logic     cmd_ready;
    logic     fault;
    addr_t    fault_addr;
    logic     done;
    lsu_rsp_t rsp;

    // reference memory and in-order expectations
    word_t       ref_mem [mem_words_c];
    lsu_rsp_t    rsp_q[$];
    lsu_rsp_t    exp_q[$];
    addr_t       fault_q[$];
    addr_t       exp_fault_q[$];
    logic [31:0] seed;
    string       test_name;

    lsu_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_ready  (cmd_ready),
        .fault      (fault),
        .fault_addr (fault_addr),
        .done       (done),
        .rsp        (rsp)
    );

    always #2 clk = ~clk;

    // completions and faults as seen at the clock edge
    always @(posedge clk) begin
        if (done) begin
            rsp_q.push_back(rsp);
        end
        if (fault) begin
            fault_q.push_back(fault_addr);
        end
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(string what, word_t exp, word_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s %s expected %h actual %h",
                                test_name, what, exp, act));
        end
    endtask

    task automatic check_addr(string what, addr_t exp, addr_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s %s expected %h actual %h",
                                test_name, what, exp, act));
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s %s expected %b actual %b",
                                test_name, what, exp, act));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // byte by byte merge at the addressed lanes
    function automatic void model_store(addr_t a, funct3_t f3, word_t d);
        int n;
        n = 1 << f3[1:0];
        for (int i = 0; i < n; i++) begin
            ref_mem[a[9:2]][8*(int'(a[1:0])+i) +: 8] = d[8*i +: 8];
        end
    endfunction

    function automatic word_t model_load(addr_t a, funct3_t f3);
        int    n;
        word_t v;
        n = 1 << f3[1:0];
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = ref_mem[a[9:2]][8*(int'(a[1:0])+i) +: 8];
        end
        // signed loads copy the top loaded bit upwards
        if (!f3[2] && n < 4 && v[8*n-1]) begin
            for (int i = 8*n; i < 32; i++) begin
                v[i] = 1'b1;
            end
        end
        return v;
    endfunction

    // records the expected outcome and then strobes the command
    task automatic send_cmd(logic st, funct3_t f3, addr_t base, imm12_t off, word_t d);
        addr_t    ea;
        logic     bad;
        mem_cmd_t c;
        lsu_rsp_t e;
        int       waited;
        // immediate read as a value in -2048 to 2047
        ea  = base + addr_t'(int'(off) - (off[11] ? 4096 : 0));
        bad = (f3 == 3'd3) || (f3 >= 3'd6) || (f3[1:0] == 2'd1 && ea[0]) ||
              (f3[1:0] == 2'd2 && ea[1:0] != 2'd0);
        if (bad) begin
            exp_fault_q.push_back(ea);
        end else begin
            e.is_store = st;
            e.addr     = ea;
            if (st) begin
                model_store(ea, f3, d);
                e.rdata = '0;
            end else begin
                e.rdata = model_load(ea, f3);
            end
            exp_q.push_back(e);
        end
        c.is_store = st;
        c.funct3   = f3;
        c.base     = base;
        c.offset   = off;
        c.wdata    = d;
        waited = 0;
        while (!cmd_ready) begin
            waited++;
            if (waited > timeout_c) begin
                abort_run($sformatf("cmd_ready stayed low too long in %s", test_name));
            end
            @(posedge clk);
        end
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(posedge clk);
        cmd_valid <= 1'b0;
        // the push reaches the queue count one edge after the strobe is taken
        @(posedge clk);
        @(posedge clk);
    endtask

    task automatic drain_and_check();
        lsu_rsp_t got;
        lsu_rsp_t e;
        addr_t    fa;
        addr_t    efa;
        int       waited;
        while (exp_q.size() > 0) begin
            waited = 0;
            while (rsp_q.size() == 0) begin
                waited++;
                if (waited > timeout_c) begin
                    abort_run($sformatf("no completion arrived in %s", test_name));
                end
                @(posedge clk);
            end
            got = rsp_q.pop_front();
            e   = exp_q.pop_front();
            check_bit("is_store", e.is_store, got.is_store);
            check_addr("addr", e.addr, got.addr);
            check_word("rdata", e.rdata, got.rdata);
        end
        while (exp_fault_q.size() > 0) begin
            waited = 0;
            while (fault_q.size() == 0) begin
                waited++;
                if (waited > timeout_c) begin
                    abort_run($sformatf("no fault pulse arrived in %s", test_name));
                end
                @(posedge clk);
            end
            fa  = fault_q.pop_front();
            efa = exp_fault_q.pop_front();
            check_addr("fault_addr", efa, fa);
        end
        check_bit("extra done", 1'b0, rsp_q.size() != 0);
        check_bit("extra fault", 1'b0, fault_q.size() != 0);
    endtask

    task automatic test_word_roundtrip();
        test_name = "test_word_roundtrip";
        for (int i = 0; i < 4; i++) begin
            send_cmd(1'b1, 3'd2, addr_t'(32'h200 + i*16), 12'd0, lcg_next());
        end
        for (int i = 0; i < 4; i++) begin
            send_cmd(1'b0, 3'd2, addr_t'(32'h200 + i*16), 12'd0, '0);
        end
        drain_and_check();
    endtask

    task automatic test_sub_word();
        test_name = "test_sub_word";
        send_cmd(1'b1, 3'd2, 32'h300, 12'd0, 32'h1234_5678);
        send_cmd(1'b1, 3'd1, 32'h300, 12'd2, 32'h0000_c3a5);
        send_cmd(1'b1, 3'd0, 32'h300, 12'd1, 32'h0000_0080);
        // unsigned code on a store still writes one byte
        send_cmd(1'b1, 3'd4, 32'h300, 12'd3, 32'hffff_ff9c);
        send_cmd(1'b0, 3'd2, 32'h300, 12'd0, '0);
        for (int i = 0; i < 4; i++) begin
            send_cmd(1'b0, 3'd0, 32'h300, imm12_t'(i), '0);
            send_cmd(1'b0, 3'd4, 32'h300, imm12_t'(i), '0);
        end
        for (int i = 0; i < 4; i += 2) begin
            send_cmd(1'b0, 3'd1, 32'h300, imm12_t'(i), '0);
            send_cmd(1'b0, 3'd5, 32'h300, imm12_t'(i), '0);
        end
        drain_and_check();
    endtask

    task automatic test_misaligned();
        test_name = "test_misaligned";
        send_cmd(1'b1, 3'd2, 32'h320, 12'd0, 32'ha5a5_5a5a);
        send_cmd(1'b1, 3'd1, 32'h321, 12'd0, 32'h0000_ffff);
        send_cmd(1'b1, 3'd2, 32'h320, 12'd2, 32'hffff_ffff);
        send_cmd(1'b1, 3'd3, 32'h320, 12'd0, 32'h0000_0000);
        send_cmd(1'b0, 3'd5, 32'h323, 12'd0, '0);
        send_cmd(1'b0, 3'd6, 32'h320, 12'd0, '0);
        // memory must still hold the first store
        send_cmd(1'b0, 3'd2, 32'h320, 12'd0, '0);
        drain_and_check();
    endtask

    task automatic test_offset_add();
        test_name = "test_offset_add";
        send_cmd(1'b1, 3'd2, 32'h400, 12'hff8, 32'h0bad_f00d);
        send_cmd(1'b0, 3'd2, 32'h3fc, 12'hffc, '0);
        send_cmd(1'b0, 3'd4, 32'h3fa, 12'hfff, '0);
        send_cmd(1'b0, 3'd1, 32'h3f0, 12'h00a, '0);
        drain_and_check();
    endtask

    task automatic test_backpressure_order();
        int   n;
        logic dropped;
        test_name = "test_backpressure_order";
        n       = 0;
        dropped = 1'b0;
        while (!dropped && n < 4 * fifo_depth_c) begin
            send_cmd(1'b1, 3'd2, addr_t'(32'h100 + n*4), 12'd0, lcg_next());
            n++;
            check_bit("outstanding within limit", 1'b1,
                      (n - rsp_q.size()) <= fifo_depth_c + 1);
            dropped = !cmd_ready;
        end
        check_bit("cmd_ready dropped", 1'b1, dropped);
        for (int i = 0; i < n; i++) begin
            send_cmd(1'b0, 3'd2, addr_t'(32'h100 + i*4), 12'd0, '0);
        end
        drain_and_check();
    endtask

    task automatic test_random();
        logic [31:0] r;
        addr_t       ea;
        imm12_t      off;
        test_name = "test_random";
        for (int i = 0; i < 64; i++) begin
            send_cmd(1'b1, 3'd2, addr_t'(i*4), 12'd0, lcg_next());
        end
        for (int i = 0; i < 200; i++) begin
            r   = lcg_next();
            // upper LCG bits pick word, byte offset, code and direction
            ea  = {24'd0, r[29:24], r[31:30]};
            off = r[17:6];
            send_cmd(r[19], r[22:20], ea - {{20{off[11]}}, off}, off, lcg_next());
        end
        drain_and_check();
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        seed      = 32'h3050_24c1;
        test_name = "reset";
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_bit("cmd_ready", 1'b1, cmd_ready);
        check_bit("done", 1'b0, done);
        check_bit("fault", 1'b0, fault);
        test_word_roundtrip();
        test_sub_word();
        test_misaligned();
        test_offset_add();
        test_backpressure_order();
        test_random();
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- logic/lsu_top.sv
module lsu_top
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cmd_valid,
    input  mem_cmd_t cmd,
    output logic     cmd_ready,
    output logic     fault,
    output addr_t    fault_addr,
    output logic     done,
    output lsu_rsp_t rsp
);

    logic     push;
    logic     pop;
    logic     empty;
    logic     almost_full;
    lsu_req_t req;
    lsu_req_t head;

    addr_t araddr;
    logic  arvalid;
    logic  arready;
    word_t rdata;
    logic  rvalid;
    logic  rready;
    addr_t awaddr;
    logic  awvalid;
    logic  awready;
    word_t wdata;
    strb_t wstrb;
    logic  wvalid;
    logic  wready;
    logic  bvalid;
    logic  bready;

    // almost_full already counts the push in flight from issue
    assign cmd_ready = !almost_full;

    mem_req_issue issue0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .push       (push),
        .req        (req),
        .fault      (fault),
        .fault_addr (fault_addr)
    );

    req_fifo fifo0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (push),
        .req_in      (req),
        .pop         (pop),
        .req_out     (head),
        .full        (),
        .empty       (empty),
        .almost_full (almost_full)
    );

    lsu lsu0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .empty   (empty),
        .head    (head),
        .pop     (pop),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready),
        .done    (done),
        .rsp     (rsp)
    );

    sram_axi sram0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

//--- logic/sram_axi.sv
module sram_axi
    import lsu_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,
    output word_t rdata,
    output logic  rvalid,
    input  logic  rready,

    input  addr_t awaddr,
    input  logic  awvalid,
    output logic  awready,
    input  word_t wdata,
    input  strb_t wstrb,
    input  logic  wvalid,
    output logic  wready,
    output logic  bvalid,
    input  logic  bready
);

    word_t    mem [mem_words_c];
    mem_idx_t aw_idx;
    logic     aw_taken;

    // read side, ready one cycle after valid, data the cycle after the transfer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= mem[araddr[mem_idx_w_c+1:2]];
        end
    end

    // write side, address first, then data, then response
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            aw_taken <= 1'b0;
        end else begin
            awready <= awvalid && !awready && !aw_taken;
            wready  <= wvalid && !wready && aw_taken;
            if (awvalid && awready) begin
                aw_taken <= 1'b1;
            end else if (wvalid && wready) begin
                aw_taken <= 1'b0;
            end
            if (wvalid && wready) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            aw_idx <= awaddr[mem_idx_w_c+1:2];
        end
        // byte merge under the strobe
        if (wvalid && wready) begin
            for (int b = 0; b < xlen_c / 8; b++) begin
                if (wstrb[b]) begin
                    mem[aw_idx][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- logic/lsu.sv
module lsu
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     empty,
    input  lsu_req_t head,
    output logic     pop,

    // read address and data
    output addr_t    araddr,
    output logic     arvalid,
    input  logic     arready,
    input  word_t    rdata,
    input  logic     rvalid,
    output logic     rready,

    // write address, data and response
    output addr_t    awaddr,
    output logic     awvalid,
    input  logic     awready,
    output word_t    wdata,
    output strb_t    wstrb,
    output logic     wvalid,
    input  logic     wready,
    input  logic     bvalid,
    output logic     bready,

    output logic     done,
    output lsu_rsp_t rsp
);

    lsu_fsm_e state;
    lsu_req_t req_q;
    word_t    load_data;

    // shift the addressed lanes down, then extend
    function automatic word_t extend_load(word_t raw, addr_t addr, ls_size_e size,
                                          logic is_signed);
        word_t shifted;
        word_t result;
        shifted = raw >> {addr[1:0], 3'b000};
        case (size)
            size_byte: result = {{24{is_signed & shifted[7]}}, shifted[7:0]};
            size_half: result = {{16{is_signed & shifted[15]}}, shifted[15:0]};
            default:   result = shifted;
        endcase
        return result;
    endfunction

    // one request at a time, taken only from idle
    assign pop = (state == st_idle) && !empty;

    assign arvalid = (state == st_ar);
    assign awvalid = (state == st_aw);
    assign wvalid  = (state == st_w);
    assign rready  = 1'b1;
    assign bready  = 1'b1;

    // memory ignores the low bits, lanes carry the byte offset
    assign araddr = req_q.addr;
    assign awaddr = req_q.addr;

    // store data onto byte lanes
    always_comb begin
        wdata = req_q.wdata << {req_q.addr[1:0], 3'b000};
        case (req_q.size)
            size_byte: wstrb = strb_t'(4'b0001) << req_q.addr[1:0];
            size_half: wstrb = req_q.addr[1] ? strb_t'(4'b1100) : strb_t'(4'b0011);
            size_word: wstrb = strb_t'(4'b1111);
            default:   wstrb = '0;
        endcase
    end

    assign load_data = extend_load(rdata, req_q.addr, req_q.size, req_q.is_signed);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (!empty) begin
                        state <= head.is_store ? st_aw : st_ar;
                    end
                end
                st_ar: begin
                    if (arready) begin
                        state <= st_r;
                    end
                end
                st_r: begin
                    if (rvalid) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end
                // stores run address, data, response strictly in order
                st_aw: begin
                    if (awready) begin
                        state <= st_w;
                    end
                end
                st_w: begin
                    if (wready) begin
                        state <= st_b;
                    end
                end
                st_b: begin
                    if (bvalid) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            req_q <= head;
        end
        if (state == st_r && rvalid) begin
            rsp.is_store <= 1'b0;
            rsp.addr     <= req_q.addr;
            rsp.rdata    <= load_data;
        end
        if (state == st_b && bvalid) begin
            rsp.is_store <= 1'b1;
            rsp.addr     <= req_q.addr;
            rsp.rdata    <= '0;
        end
    end

endmodule

//--- logic/req_fifo.sv
module req_fifo
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  lsu_req_t req_in,
    input  logic     pop,
    output lsu_req_t req_out,
    output logic     full,
    output logic     empty,
    output logic     almost_full
);

    lsu_req_t  entries [fifo_depth_c];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;
    logic      do_push;
    logic      do_pop;

    assign full        = (count == fifo_cnt_t'(fifo_depth_c));
    assign empty       = (count == '0);
    // leaves room for the push still in flight from issue
    assign almost_full = (count >= fifo_cnt_t'(fifo_depth_c - 1));

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head is always the oldest entry
    assign req_out = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= req_in;
        end
    end

endmodule

//--- logic/mem_req_issue.sv
module mem_req_issue
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cmd_valid,
    input  mem_cmd_t cmd,
    output logic     push,
    output lsu_req_t req,
    output logic     fault,
    output addr_t    fault_addr
);

    addr_t    eff_addr;
    ls_size_e size;
    logic     code_ok;
    logic     aligned;

    // base plus sign-extended immediate
    assign eff_addr = cmd.base + {{(xlen_c-12){cmd.offset[11]}}, cmd.offset};

    // funct3[1:0] selects the size, funct3[2] marks unsigned loads
    always_comb begin
        size    = size_word;
        code_ok = 1'b1;
        case (cmd.funct3[1:0])
            2'b00: size = size_byte;
            2'b01: size = size_half;
            2'b10: size = size_word;
            default: code_ok = 1'b0;
        endcase
        // there is no unsigned word access
        if (cmd.funct3 == 3'b110) begin
            code_ok = 1'b0;
        end
    end

    assign aligned = !((size == size_half && eff_addr[0]) ||
                       (size == size_word && eff_addr[1:0] != 2'b00));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            push  <= 1'b0;
            fault <= 1'b0;
        end else begin
            push  <= cmd_valid && code_ok && aligned;
            fault <= cmd_valid && !(code_ok && aligned);
        end
    end

    always_ff @(posedge clk) begin
        req.is_store  <= cmd.is_store;
        req.size      <= size;
        req.is_signed <= !cmd.funct3[2] && !cmd.is_store;
        req.addr      <= eff_addr;
        req.wdata     <= cmd.wdata;
        fault_addr    <= eff_addr;
    end

endmodule

//--- logic/lsu_pkg.sv
package lsu_pkg;

    // datapath and address width
    localparam int xlen_c = 32;

    // word-wide SRAM, indexed by addr[9:2]
    localparam int mem_words_c = 256;
    localparam int mem_idx_w_c = $clog2(mem_words_c);

    // request queue between issue and lsu
    localparam int fifo_depth_c = 4;
    localparam int fifo_ptr_w_c = $clog2(fifo_depth_c);

    typedef logic [xlen_c-1:0]       addr_t;
    typedef logic [xlen_c-1:0]       word_t;
    typedef logic [xlen_c/8-1:0]     strb_t;
    typedef logic [11:0]             imm12_t;
    typedef logic [2:0]              funct3_t;
    typedef logic [mem_idx_w_c-1:0]  mem_idx_t;
    typedef logic [fifo_ptr_w_c-1:0] fifo_ptr_t;
    // one extra bit so a full queue is distinct from an empty one
    typedef logic [fifo_ptr_w_c:0]   fifo_cnt_t;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } ls_size_e;

    typedef enum logic [2:0] {
        st_idle,
        st_ar,
        st_r,
        st_aw,
        st_w,
        st_b
    } lsu_fsm_e;

    // command as issued by the core
    typedef struct packed {
        logic    is_store;
        funct3_t funct3;
        addr_t   base;
        imm12_t  offset;
        word_t   wdata;
    } mem_cmd_t;

    // decoded and aligned request, one queue entry
    typedef struct packed {
        logic     is_store;
        ls_size_e size;
        logic     is_signed;
        addr_t    addr;
        word_t    wdata;
    } lsu_req_t;

    typedef struct packed {
        logic  is_store;
        addr_t addr;
        word_t rdata;
    } lsu_rsp_t;

endpackage
